//--- bench/tb_mul_ex_top.sv
/*
  Directed testbench for the execute-stage multiply block
  Runs MUL, the MULH family, writeback stalls and divide codes
  against a 64-bit reference product
*/

`timescale 1ns/100ps
`default_nettype none

module tb_mul_ex_top;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 8;
  localparam int N_CORNER     = 4;
  localparam int MUL_RANDOM   = 50;
  localparam int MULH_RANDOM  = 20;
  localparam int STALL_RUNS   = 8;
  localparam int MIXED_RUNS   = 40;
  // Corner grids for MUL and three MULH ops, plus four divide codes
  localparam int REQ_TOTAL = 4 * N_CORNER * N_CORNER + MUL_RANDOM + 3 * MULH_RANDOM
                             + STALL_RUNS + MIXED_RUNS + 4;
  localparam int WATCHDOG_CYCLES = REQ_TOTAL * 200 + RESET_CYCLES;

  logic             clk;
  logic             rst_n;
  ex_pkg::ex_req_t  req_i;
  logic             wb_ready_i;
  ex_pkg::wb_data_t wb_o;
  logic             busy_o;

  integer           seed;
  mul_pkg::word_t   corner [N_CORNER];

  mul_ex_top mul_ex_top_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_i      (req_i),
    .wb_ready_i (wb_ready_i),
    .wb_o       (wb_o),
    .busy_o     (busy_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////
  // Reference and checks
  ////////////////////

  // Full 64-bit product with the signedness of each funct3
  function automatic mul_pkg::word_t expected_result(input logic [2:0] funct,
                                                     input mul_pkg::word_t a,
                                                     input mul_pkg::word_t b);
    logic [63:0] ext_a;
    logic [63:0] ext_b;
    logic [63:0] product;
    ext_a = {32'h0, a};
    ext_b = {32'h0, b};
    // A signed for MULH and MULHSU, B only for MULH
    if (funct == 3'd1 || funct == 3'd2) ext_a = {{32{a[31]}}, a};
    if (funct == 3'd1) ext_b = {{32{b[31]}}, b};
    product = ext_a * ext_b;
    if (funct == 3'd0) return product[31:0];
    else return product[63:32];
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      $display("ERROR at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
      $display("*** FAILED ***");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // Holds the request until wb_o shows it, counting edges and busy cycles
  // A nonzero stall drops wb_ready_i once the sequencer sits in FINISH
  task automatic issue_request(input logic [2:0] funct, input mul_pkg::word_t a,
                               input mul_pkg::word_t b, input int stall,
                               output mul_pkg::word_t result, output logic illegal,
                               output int cycles, output int busy_cycles);
    int stall_left;
    bit done;
    stall_left  = stall;
    done        = 1'b0;
    cycles      = 0;
    busy_cycles = 0;
    req_i.valid = 1'b1;
    req_i.funct = ex_pkg::mul_funct_e'(funct);
    req_i.op_a  = a;
    req_i.op_b  = b;
    while (!done) begin
      @(posedge clk);
      cycles++;
      @(negedge clk);
      if (busy_o) busy_cycles++;
      if (wb_o.valid) begin
        done = 1'b1;
      end else if (!wb_ready_i) begin
        stall_left--;
        if (stall_left == 0) wb_ready_i = 1'b1;
      end else if (cycles == 4 && stall_left > 0) begin
        // Four edges after issue the sequencer is in FINISH
        wb_ready_i = 1'b0;
      end
    end
    result      = wb_o.result;
    illegal     = wb_o.illegal;
    req_i.valid = 1'b0;
  endtask

  // One request with its expected result, flag, latency and busy time
  task automatic expect_op(input logic [2:0] funct, input mul_pkg::word_t a,
                           input mul_pkg::word_t b, input int stall);
    mul_pkg::word_t result;
    logic           illegal;
    int             cycles;
    int             busy_cycles;
    issue_request(funct, a, b, stall, result, illegal, cycles, busy_cycles);
    if (funct[2]) begin
      // Divide codes bypass the multiplier
      check_value("wb_o.illegal", 1, illegal);
      check_value("wb_o.result", 0, result);
      check_value("latency", 1, cycles);
      check_value("busy_o cycles", 0, busy_cycles);
    end else begin
      check_value("wb_o.result", expected_result(funct, a, b), result);
      check_value("wb_o.illegal", 0, illegal);
      if (funct == 3'd0) begin
        check_value("latency", 1, cycles);
        check_value("busy_o cycles", 0, busy_cycles);
      end else begin
        check_value("latency", 5 + stall, cycles);
        check_value("busy_o cycles", 3, busy_cycles);
      end
    end
  endtask

  ////////////////////
  // Directed tests
  ////////////////////

  task automatic check_reset_state();
    check_value("wb_o.valid", 0, wb_o.valid);
    check_value("busy_o", 0, busy_o);
  endtask

  task automatic mul_low_word();
    for (int i = 0; i < N_CORNER; i++) begin
      for (int j = 0; j < N_CORNER; j++) expect_op(3'd0, corner[i], corner[j], 0);
    end
    repeat (MUL_RANDOM) expect_op(3'd0, $random(seed), $random(seed), 0);
  endtask

  // MULH, MULHSU and MULHU in turn
  task automatic mulh_upper_word();
    for (int f = 1; f <= 3; f++) begin
      for (int i = 0; i < N_CORNER; i++) begin
        for (int j = 0; j < N_CORNER; j++) expect_op(f[2:0], corner[i], corner[j], 0);
      end
      repeat (MULH_RANDOM) expect_op(f[2:0], $random(seed), $random(seed), 0);
    end
  endtask

  task automatic writeback_stall();
    int stall;
    repeat (STALL_RUNS) begin
      stall = ($unsigned($random(seed)) % 8) + 1;
      expect_op(3'd1, $random(seed), $random(seed), stall);
    end
  endtask

  // Leftover carry or sum would corrupt the next upper word
  task automatic mixed_back_to_back();
    logic [2:0] funct;
    repeat (MIXED_RUNS) begin
      funct = $unsigned($random(seed)) % 4;
      expect_op(funct, $random(seed), $random(seed), 0);
    end
  endtask

  task automatic divide_codes_illegal();
    for (int f = 4; f <= 7; f++) expect_op(f[2:0], $random(seed), $random(seed), 0);
  endtask

  ////////////////////
  // Sequence
  ////////////////////

  initial begin
    seed       = 10;
    rst_n      = 1'b0;
    wb_ready_i = 1'b1;
    req_i      = '0;
    corner[0]  = 32'h0000_0000;
    corner[1]  = 32'h0000_0001;
    corner[2]  = 32'hFFFF_FFFF;
    corner[3]  = 32'h8000_0000;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_reset_state();
    mul_low_word();
    mulh_upper_word();
    writeback_stall();
    mixed_back_to_back();
    divide_codes_illegal();
    $display("*** PASSED ***");
    $finish;
  end

  // Bound from the request count, 200 cycles each
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the run hung", WATCHDOG_CYCLES);
    $display("*** FAILED ***");
    $fatal(1, "Timeout");
  end

endmodule

`default_nettype wire

//--- common/ex_pkg.sv
/*
  Execute stage request and writeback types
  The M-extension funct3 codes and the request and writeback bundles
*/

`default_nettype none

package ex_pkg;

  // funct3 of the OP opcode with funct7 = 1
  typedef enum logic [2:0] {
    FN_MUL    = 3'd0,
    FN_MULH   = 3'd1,
    FN_MULHSU = 3'd2,
    FN_MULHU  = 3'd3,
    // Divide side, not run by this block
    FN_DIV    = 3'd4,
    FN_DIVU   = 3'd5,
    FN_REM    = 3'd6,
    FN_REMU   = 3'd7
  } mul_funct_e;

  // Request as held by the issuer until writeback
  typedef struct packed {
    logic           valid;
    mul_funct_e     funct;
    mul_pkg::word_t op_a;
    mul_pkg::word_t op_b;
  } ex_req_t;

  // One writeback entry
  typedef struct packed {
    logic           valid;
    logic           illegal;
    mul_pkg::word_t result;
  } wb_data_t;

endpackage

`default_nettype wire

//--- common/mul_macros.svh
/*
  Width settings for the M-extension multiply block
  Shared by the multiplier types and the halfword datapath
*/

`ifndef MUL_MACROS_SVH
`define MUL_MACROS_SVH

// Operand and result word
`define MUL_XLEN 32

// One operand half as fed to the 17x17 multiplier
`define MUL_HLEN 16

// Right shift after the low-low and high-low steps
// Drops the half already accounted for in the low word
`define MUL_H_SHIFT 16

`endif

//--- common/mul_pkg.sv
/*
  Multiplier internal types
  Word and halfword widths, the operator and the MULH sequencer states
*/

`default_nettype none

`include "mul_macros.svh"

package mul_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Operand or result word
  typedef logic [`MUL_XLEN-1:0] word_t;

  // Halfword with one extension bit for signed or unsigned use
  typedef logic [`MUL_HLEN:0] half_ext_t;

  // Partial-product sum with two guard bits above the word
  typedef logic [`MUL_XLEN+1:0] acc_t;

  ////////////////////
  // Control
  ////////////////////

  // Low word in one cycle, or upper word over several
  typedef enum logic [0:0] {
    MUL_M32 = 1'b0,
    MUL_H   = 1'b1
  } mul_opcode_e;

  // MULH sequencer
  typedef enum logic [2:0] {
    IDLE_MULT = 3'd0,
    STEP0     = 3'd1,
    STEP1     = 3'd2,
    STEP2     = 3'd3,
    FINISH    = 3'd4
  } mult_state_e;

endpackage

`default_nettype wire

//--- mult/mult_unit.sv
/*
  Integer multiplier of the execute stage
  MUL takes the low word from a single-cycle 32x32 array
  The MULH family steps a 17x17 signed multiplier over four partial products
  and accumulates them into the upper word
*/

`timescale 1ns/100ps
`default_nettype none

`include "mul_macros.svh"

module mult_unit (
  input  wire                        clk,
  input  wire                        rst_n,

  input  wire                        enable_i,
  input  wire mul_pkg::mul_opcode_e  operator_i,
  // Bit 0 for operand A, bit 1 for operand B
  input  wire [1:0]                  signed_i,

  input  wire mul_pkg::word_t        op_a_i,
  input  wire mul_pkg::word_t        op_b_i,

  // Writeback can take the result
  input  wire                        ex_ready_i,

  output mul_pkg::word_t             result_o,
  output logic                       multicycle_o,
  output logic                       ready_o
);

  // Halfword datapath
  mul_pkg::half_ext_t   short_op_a;
  mul_pkg::half_ext_t   short_op_b;
  // Saved carry on top of the accumulated word
  logic [`MUL_XLEN:0]   short_addend;
  mul_pkg::acc_t        short_mul;
  mul_pkg::acc_t        short_mac;
  mul_pkg::acc_t        short_result;

  // Single-cycle low word
  mul_pkg::word_t       int_result;

  // Sequencer controls
  logic [1:0]           mulh_subword;
  logic [1:0]           mulh_signed;
  logic                 mulh_shift;
  logic                 mulh_arith;
  logic                 mulh_ready;
  logic                 acc_save;
  logic                 carry_save;
  logic                 carry_clear;
  logic                 mulh_clear;

  mul_pkg::mult_state_e state_q;
  mul_pkg::mult_state_e state_d;
  logic                 carry_q;
  mul_pkg::acc_t        acc_q;

  ////////////////////
  // Halfword multiplier
  ////////////////////

  // Bit 0 picks the upper half of A, bit 1 the upper half of B
  assign short_op_a[`MUL_HLEN-1:0] = mulh_subword[0] ? op_a_i[`MUL_XLEN-1:`MUL_HLEN]
                                                     : op_a_i[`MUL_HLEN-1:0];
  assign short_op_b[`MUL_HLEN-1:0] = mulh_subword[1] ? op_b_i[`MUL_XLEN-1:`MUL_HLEN]
                                                     : op_b_i[`MUL_HLEN-1:0];

  // Extension bit, zero for an unsigned half
  assign short_op_a[`MUL_HLEN] = mulh_signed[0] & short_op_a[`MUL_HLEN-1];
  assign short_op_b[`MUL_HLEN] = mulh_signed[1] & short_op_b[`MUL_HLEN-1];

  assign short_addend = {carry_q, acc_q[`MUL_XLEN-1:0]};

  assign short_mul = $signed(short_op_a) * $signed(short_op_b);
  assign short_mac = $signed(short_addend) + $signed(short_mul);

  // Guard bits only survive for the signed steps
  // shift of 16 drops the low half already folded in
  assign short_result = $signed({mulh_arith & short_mac[`MUL_XLEN+1],
                                 mulh_arith & short_mac[`MUL_XLEN],
                                 short_mac[`MUL_XLEN-1:0]})
                        >>> (mulh_shift ? `MUL_H_SHIFT : 0);

  ////////////////////
  // MULH sequencer
  ////////////////////

  always_comb begin
    state_d      = state_q;
    mulh_subword = 2'b00;
    mulh_signed  = 2'b00;
    mulh_shift   = 1'b0;
    mulh_arith   = 1'b0;
    mulh_ready   = 1'b0;
    acc_save     = 1'b0;
    carry_save   = 1'b0;
    carry_clear  = 1'b0;
    mulh_clear   = 1'b0;
    multicycle_o = 1'b0;

    case (state_q)
      mul_pkg::IDLE_MULT: begin
        // MUL answers right here
        mulh_ready = 1'b1;
        if (enable_i && (operator_i == mul_pkg::MUL_H)) begin
          mulh_ready = 1'b0;
          state_d    = mul_pkg::STEP0;
        end
      end
      mul_pkg::STEP0: begin
        // AL*BL, unsigned and never over 32 bits
        multicycle_o = 1'b1;
        mulh_shift   = 1'b1;
        acc_save     = 1'b1;
        state_d      = mul_pkg::STEP1;
      end
      mul_pkg::STEP1: begin
        // AL*BH, signed only if B is
        // 33-bit sum, keep its top bit as carry
        multicycle_o = 1'b1;
        mulh_subword = 2'b10;
        mulh_signed  = {signed_i[1], 1'b0};
        mulh_arith   = 1'b1;
        acc_save     = 1'b1;
        carry_save   = 1'b1;
        state_d      = mul_pkg::STEP2;
      end
      mul_pkg::STEP2: begin
        // AH*BL, signed only if A is
        // Bits above 32 get shifted back down, so the carry goes
        multicycle_o = 1'b1;
        mulh_subword = 2'b01;
        mulh_signed  = {1'b0, signed_i[0]};
        mulh_shift   = 1'b1;
        mulh_arith   = 1'b1;
        acc_save     = 1'b1;
        carry_save   = 1'b1;
        carry_clear  = 1'b1;
        state_d      = mul_pkg::FINISH;
      end
      mul_pkg::FINISH: begin
        // AH*BH plus the running sum is the upper word
        mulh_subword = 2'b11;
        mulh_signed  = signed_i;
        mulh_ready   = 1'b1;
        if (ex_ready_i) begin
          mulh_clear = 1'b1;
          state_d    = mul_pkg::IDLE_MULT;
        end
      end
      default: begin
        state_d = mul_pkg::IDLE_MULT;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= mul_pkg::IDLE_MULT;
      carry_q <= 1'b0;
      acc_q   <= '0;
    end else begin
      state_q <= state_d;
      if (mulh_clear) begin
        // Next op starts from an empty sum
        carry_q <= 1'b0;
        acc_q   <= '0;
      end else begin
        if (acc_save) begin
          acc_q <= short_result;
        end
        if (carry_save) begin
          carry_q <= ~carry_clear & short_mac[`MUL_XLEN];
        end
      end
    end
  end

  ////////////////////
  // Result mux
  ////////////////////

  // Low word does not depend on signedness
  assign int_result = op_a_i * op_b_i;

  always_comb begin
    if (operator_i == mul_pkg::MUL_M32) begin
      result_o = int_result;
    end else begin
      result_o = short_result[`MUL_XLEN-1:0];
    end
  end

  assign ready_o = mulh_ready;

  ////////////////////
  // Checks
  ////////////////////

  // Issuer must hold the request through the whole sequence
  a_operands_stable: assert property (@(posedge clk) disable iff (!rst_n)
    multicycle_o |-> $stable(op_a_i) && $stable(op_b_i)
                     && $stable(operator_i) && $stable(signed_i))
    else $error("MULH operands changed while the sequencer was busy");

  // Result stays up until writeback takes it
  a_finish_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == mul_pkg::FINISH) && !ex_ready_i |=> state_q == mul_pkg::FINISH)
    else $error("Sequencer left FINISH under stall");

  a_no_early_ready: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q inside {mul_pkg::STEP0, mul_pkg::STEP1, mul_pkg::STEP2}) |-> !ready_o)
    else $error("Multiplier ready in the middle of a MULH");

endmodule

`default_nettype wire

//--- project.f
+incdir+common
common/mul_pkg.sv
common/ex_pkg.sv
src/mul_decoder.sv
mult/mult_unit.sv
src/ex_wb_reg.sv
src/mul_ex_top.sv
bench/tb_mul_ex_top.sv

//--- src/ex_wb_reg.sv
/*
  Execute to writeback register
  Captures a finished or illegal request and holds it under a writeback stall
*/

`timescale 1ns/100ps
`default_nettype none

module ex_wb_reg (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   req_valid_i,
  input  wire                   mul_ready_i,
  input  wire                   illegal_i,
  input  wire mul_pkg::word_t   result_i,
  // Low while writeback stalls
  input  wire                   wb_ready_i,
  output ex_pkg::wb_data_t      wb_o
);

  logic           capture;
  logic           valid_q;
  logic           illegal_q;
  mul_pkg::word_t result_q;

  // Illegal codes skip the multiplier and go straight through
  assign capture = req_valid_i && wb_ready_i && (mul_ready_i || illegal_i);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (capture) begin
      valid_q <= 1'b1;
    end else if (wb_ready_i) begin
      // Entry taken, drop it
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      illegal_q <= illegal_i;
      result_q  <= illegal_i ? '0 : result_i;
    end
  end

  assign wb_o = '{valid: valid_q, illegal: illegal_q, result: result_q};

  // An illegal code never shows up while the multiplier is mid-sequence
  a_illegal_idle: assert property (@(posedge clk) disable iff (!rst_n)
    req_valid_i && illegal_i |-> mul_ready_i)
    else $error("Illegal request seen with the multiplier busy");

endmodule

`default_nettype wire

//--- src/mul_decoder.sv
/*
  Multiply request decoder
  Turns funct3 into operator and operand signedness, flags divide codes
*/

`timescale 1ns/100ps
`default_nettype none

module mul_decoder (
  input  wire ex_pkg::ex_req_t  req_i,
  output logic                  enable_o,
  output mul_pkg::mul_opcode_e  operator_o,
  // Bit 0 for operand A, bit 1 for operand B
  output logic [1:0]            signed_o,
  output logic                  illegal_o
);

  always_comb begin
    // Idle defaults
    enable_o   = 1'b0;
    operator_o = mul_pkg::MUL_M32;
    signed_o   = 2'b00;
    illegal_o  = 1'b0;

    case (req_i.funct)
      ex_pkg::FN_MUL: begin
        // Low word is the same for any signedness
        enable_o = req_i.valid;
      end
      ex_pkg::FN_MULH: begin
        enable_o   = req_i.valid;
        operator_o = mul_pkg::MUL_H;
        signed_o   = 2'b11;
      end
      ex_pkg::FN_MULHSU: begin
        // A signed, B unsigned
        enable_o   = req_i.valid;
        operator_o = mul_pkg::MUL_H;
        signed_o   = 2'b01;
      end
      ex_pkg::FN_MULHU: begin
        enable_o   = req_i.valid;
        operator_o = mul_pkg::MUL_H;
        signed_o   = 2'b00;
      end
      default: begin
        // DIV, DIVU, REM, REMU
        illegal_o = req_i.valid;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- src/mul_ex_top.sv
/*
  Multiply block of the execute stage
  Decoder, multiplier and writeback register
*/

`timescale 1ns/100ps
`default_nettype none

module mul_ex_top (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire ex_pkg::ex_req_t  req_i,
  // Low while writeback stalls
  input  wire                   wb_ready_i,
  output ex_pkg::wb_data_t      wb_o,
  // MULH sequence in progress
  output logic                  busy_o
);

  logic                 dec_enable;
  mul_pkg::mul_opcode_e dec_operator;
  logic [1:0]           dec_signed;
  logic                 dec_illegal;
  mul_pkg::word_t       mul_result;
  logic                 mul_ready;

  mul_decoder mul_decoder_i (
    .req_i      (req_i),
    .enable_o   (dec_enable),
    .operator_o (dec_operator),
    .signed_o   (dec_signed),
    .illegal_o  (dec_illegal)
  );

  // Writeback stall doubles as the multiplier's hold
  mult_unit mult_unit_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (dec_enable),
    .operator_i   (dec_operator),
    .signed_i     (dec_signed),
    .op_a_i       (req_i.op_a),
    .op_b_i       (req_i.op_b),
    .ex_ready_i   (wb_ready_i),
    .result_o     (mul_result),
    .multicycle_o (busy_o),
    .ready_o      (mul_ready)
  );

  ex_wb_reg ex_wb_reg_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (req_i.valid),
    .mul_ready_i (mul_ready),
    .illegal_i   (dec_illegal),
    .result_i    (mul_result),
    .wb_ready_i  (wb_ready_i),
    .wb_o        (wb_o)
  );

endmodule

`default_nettype wire
